//--- hdl/fabric_consts.svh
`ifndef FABRIC_CONSTS_SVH
`define FABRIC_CONSTS_SVH

// routed word and observed-state bus
`define WORD_BITS 32
`define ROUTE_WORDS 12
`define ROUTE_SEL_BITS 4

// fabric size
`define NUM_ROUTERS 8
`define NUM_COMPARATORS 4
`define NUM_CHECKERS 2

// next-mode cycle count and history depth
`define CKS_BITS 3
`define MAX_CKS 7

`endif

//--- hdl/fabricDatapathPkg.sv
`include "fabric_consts.svh"

package fabricDatapathPkg;

	// one word as seen by routers and comparators
	typedef logic [`WORD_BITS-1:0] stateWord_t;

	// full observed-state bus, word 0 in the low bits
	typedef logic [`ROUTE_WORDS*`WORD_BITS-1:0] routeBus_t;

	typedef logic [`ROUTE_SEL_BITS-1:0] routeSel_t;

	// compare operation, all unsigned; 6 and 7 invalid
	typedef logic [2:0] cmpSel_t;

	localparam cmpSel_t cmpEqual = 3'd0;
	localparam cmpSel_t cmpNotEqual = 3'd1;
	localparam cmpSel_t cmpLess = 3'd2;
	localparam cmpSel_t cmpLessEq = 3'd3;
	localparam cmpSel_t cmpGreater = 3'd4;
	localparam cmpSel_t cmpGreaterEq = 3'd5;

endpackage

//--- hdl/fabricCheckerPkg.sv
`include "fabric_consts.svh"

package fabricCheckerPkg;

	typedef logic [`CKS_BITS-1:0] numCks_t;

	// checker mode; code 3 invalid
	typedef logic [1:0] checkSel_t;

	localparam checkSel_t chkImplication = 2'd0;
	localparam checkSel_t chkNext = 2'd1;
	localparam checkSel_t chkNever = 2'd2;

	// bit i set means a start event i+1 cycles ago
	typedef logic [`MAX_CKS-1:0] ckShift_t;

endpackage

//--- hdl/compareCfgIf.sv
`timescale 1ns/1ps

interface compareCfgIf;

	fabricDatapathPkg::stateWord_t maskA;
	fabricDatapathPkg::stateWord_t maskB;
	fabricDatapathPkg::stateWord_t constant;
	logic opBMux;
	fabricDatapathPkg::cmpSel_t resultMux;

	modport source (
		output maskA,
		output maskB,
		output constant,
		output opBMux,
		output resultMux
	);

	modport sink (
		input maskA,
		input maskB,
		input constant,
		input opBMux,
		input resultMux
	);

endinterface

//--- hdl/signalRouter.sv
`timescale 1ns/1ps
`include "fabric_consts.svh"

module signalRouter (
	input fabricDatapathPkg::routeBus_t routingInput,
	input fabricDatapathPkg::routeSel_t inputSelect,
	output fabricDatapathPkg::stateWord_t result,
	output logic configInvalid
);

	// word view of the state bus
	fabricDatapathPkg::stateWord_t [`ROUTE_WORDS-1:0] words;

	assign words = routingInput;

	always_comb begin
		configInvalid = (inputSelect >= `ROUTE_SEL_BITS'(`ROUTE_WORDS));
		result = '0;
		// selects past the last word give zero
		if (!configInvalid) begin
			result = words[inputSelect];
		end
	end

endmodule

//--- hdl/stateComparator.sv
`timescale 1ns/1ps

module stateComparator (
	input fabricDatapathPkg::stateWord_t stateA,
	input fabricDatapathPkg::stateWord_t stateB,
	input logic prevConfigInvalid,
	compareCfgIf.sink cfg,
	output logic result,
	output logic configInvalid
);

	fabricDatapathPkg::stateWord_t opA;
	fabricDatapathPkg::stateWord_t opB;
	logic cmpInvalid;

	////////////////////////////////////////////////////////////////////////////
	// operand select

	assign opA = stateA & cfg.maskA;

	// constant operand bypasses maskB
	assign opB = cfg.opBMux ? cfg.constant : (stateB & cfg.maskB);

	////////////////////////////////////////////////////////////////////////////
	// compare

	always_comb begin
		result = 1'b0;
		cmpInvalid = 1'b0;
		case (cfg.resultMux)
			fabricDatapathPkg::cmpEqual: begin
				result = (opA == opB);
			end
			fabricDatapathPkg::cmpNotEqual: begin
				result = (opA != opB);
			end
			fabricDatapathPkg::cmpLess: begin
				result = (opA < opB);
			end
			fabricDatapathPkg::cmpLessEq: begin
				result = (opA <= opB);
			end
			fabricDatapathPkg::cmpGreater: begin
				result = (opA > opB);
			end
			fabricDatapathPkg::cmpGreaterEq: begin
				result = (opA >= opB);
			end
			default: begin
				cmpInvalid = 1'b1;
			end
		endcase
	end

	// router errors ride along with our own
	assign configInvalid = prevConfigInvalid | cmpInvalid;

endmodule

//--- hdl/temporalChecker.sv
`timescale 1ns/1ps
`include "fabric_consts.svh"

module temporalChecker (
	input logic clk,
	input logic arstN,
	input logic enable,
	input logic startEvent,
	input logic testExpr,
	input logic prevConfigInvalid,
	input fabricCheckerPkg::numCks_t numCks,
	input fabricCheckerPkg::checkSel_t checkSel,
	input logic resSel,
	output logic violation,
	output logic configInvalid
);

	fabricCheckerPkg::ckShift_t startHist;
	logic resultComb;
	logic resultReg;
	logic modeInvalid;

	////////////////////////////////////////////////////////////////////////////
	// combinational check

	always_comb begin
		resultComb = 1'b0;
		modeInvalid = 1'b0;
		case (checkSel)
			fabricCheckerPkg::chkImplication: begin
				resultComb = startEvent & ~testExpr;
			end
			fabricCheckerPkg::chkNext: begin
				// start seen numCks cycles back sits in bit numCks-1
				if (numCks == '0) begin
					modeInvalid = 1'b1;
				end else begin
					resultComb = startHist[numCks - 3'd1] & ~testExpr;
				end
			end
			fabricCheckerPkg::chkNever: begin
				resultComb = startEvent & testExpr;
			end
			default: begin
				modeInvalid = 1'b1;
			end
		endcase
		if (!enable) begin
			resultComb = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// start history and registered result

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			startHist <= '0;
			resultReg <= 1'b0;
		end else if (!enable) begin
			startHist <= '0;
			resultReg <= 1'b0;
		end else begin
			startHist <= {startHist[`MAX_CKS-2:0], startEvent};
			resultReg <= resultComb;
		end
	end

	// registered path also reads zero while disabled
	assign violation = resSel ? (resultReg & enable) : resultComb;

	assign configInvalid = prevConfigInvalid | modeInvalid;

endmodule

//--- hdl/checkerBank.sv
`timescale 1ns/1ps
`include "fabric_consts.svh"

module checkerBank (
	input logic clk,
	input logic arstN,
	input logic enable,
	input logic [`NUM_CHECKERS-1:0] startEvents,
	input logic [`NUM_CHECKERS-1:0] testExprs,
	input logic [`NUM_CHECKERS-1:0] eventInvalid,
	input fabricCheckerPkg::numCks_t [`NUM_CHECKERS-1:0] numCks,
	input fabricCheckerPkg::checkSel_t [`NUM_CHECKERS-1:0] checkSel,
	input logic [`NUM_CHECKERS-1:0] resSel,
	output logic [`NUM_CHECKERS-1:0] assertionsViolated,
	output logic assertionViolated
);

	logic [`NUM_CHECKERS-1:0] violations;
	logic [`NUM_CHECKERS-1:0] checkerInvalid;

	for (genvar i = 0; i < `NUM_CHECKERS; i++) begin : genChecker
		temporalChecker u_temporalChecker (
			.clk(clk),
			.arstN(arstN),
			.enable(enable),
			.startEvent(startEvents[i]),
			.testExpr(testExprs[i]),
			.prevConfigInvalid(eventInvalid[i]),
			.numCks(numCks[i]),
			.checkSel(checkSel[i]),
			.resSel(resSel[i]),
			.violation(violations[i]),
			.configInvalid(checkerInvalid[i])
		);

		// checker 0 lands in the msb
		assign assertionsViolated[`NUM_CHECKERS-1-i] = violations[i];
	end

	// any bad config anywhere blocks the merged flag
	assign assertionViolated = (|violations) & ~(|checkerInvalid);

endmodule

//--- hdl/assertionFabric.sv
`timescale 1ns/1ps
`include "fabric_consts.svh"

module assertionFabric (
	input logic clk,
	input logic arstN,
	input logic enable,
	input fabricDatapathPkg::routeBus_t routingInput,
	input fabricDatapathPkg::routeSel_t [`NUM_ROUTERS-1:0] routeSel,
	input fabricDatapathPkg::stateWord_t [`NUM_COMPARATORS-1:0] maskA,
	input fabricDatapathPkg::stateWord_t [`NUM_COMPARATORS-1:0] maskB,
	input fabricDatapathPkg::stateWord_t [`NUM_COMPARATORS-1:0] constant,
	input logic [`NUM_COMPARATORS-1:0] opBMux,
	input fabricDatapathPkg::cmpSel_t [`NUM_COMPARATORS-1:0] resultMux,
	input fabricCheckerPkg::numCks_t [`NUM_CHECKERS-1:0] numCks,
	input fabricCheckerPkg::checkSel_t [`NUM_CHECKERS-1:0] checkSel,
	input logic [`NUM_CHECKERS-1:0] resSel,
	output logic [`NUM_CHECKERS-1:0] assertionsViolated,
	output logic assertionViolated
);

	fabricDatapathPkg::stateWord_t [`NUM_ROUTERS-1:0] routed;
	logic [`NUM_ROUTERS-1:0] routeInvalid;
	logic [`NUM_COMPARATORS-1:0] cmpResult;
	logic [`NUM_COMPARATORS-1:0] cmpInvalid;
	logic [`NUM_CHECKERS-1:0] startEvents;
	logic [`NUM_CHECKERS-1:0] testExprs;
	logic [`NUM_CHECKERS-1:0] eventInvalid;

	////////////////////////////////////////////////////////////////////////////
	// routers

	for (genvar r = 0; r < `NUM_ROUTERS; r++) begin : genRouter
		signalRouter u_signalRouter (
			.routingInput(routingInput),
			.inputSelect(routeSel[r]),
			.result(routed[r]),
			.configInvalid(routeInvalid[r])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// comparators, routers 2k and 2k+1 feed comparator k

	for (genvar k = 0; k < `NUM_COMPARATORS; k++) begin : genComparator
		compareCfgIf cmpCfg ();

		assign cmpCfg.maskA = maskA[k];
		assign cmpCfg.maskB = maskB[k];
		assign cmpCfg.constant = constant[k];
		assign cmpCfg.opBMux = opBMux[k];
		assign cmpCfg.resultMux = resultMux[k];

		stateComparator u_stateComparator (
			.stateA(routed[2*k]),
			.stateB(routed[2*k+1]),
			.prevConfigInvalid(routeInvalid[2*k] | routeInvalid[2*k+1]),
			.cfg(cmpCfg.sink),
			.result(cmpResult[k]),
			.configInvalid(cmpInvalid[k])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// checkers, comparator 2j starts and 2j+1 tests

	for (genvar j = 0; j < `NUM_CHECKERS; j++) begin : genEvents
		assign startEvents[j] = cmpResult[2*j];
		assign testExprs[j] = cmpResult[2*j+1];
		assign eventInvalid[j] = cmpInvalid[2*j] | cmpInvalid[2*j+1];
	end

	checkerBank u_checkerBank (
		.clk(clk),
		.arstN(arstN),
		.enable(enable),
		.startEvents(startEvents),
		.testExprs(testExprs),
		.eventInvalid(eventInvalid),
		.numCks(numCks),
		.checkSel(checkSel),
		.resSel(resSel),
		.assertionsViolated(assertionsViolated),
		.assertionViolated(assertionViolated)
	);

endmodule

//--- sim/fabric_assertions.sv
`timescale 1ns/1ps
`include "fabric_consts.svh"

module fabric_assertions (
	input logic clk,
	input logic arstN,
	input logic enable,
	input fabricDatapathPkg::routeBus_t routingInput,
	input fabricDatapathPkg::routeSel_t [`NUM_ROUTERS-1:0] routeSel,
	input fabricDatapathPkg::stateWord_t [`NUM_COMPARATORS-1:0] maskA,
	input fabricDatapathPkg::stateWord_t [`NUM_COMPARATORS-1:0] maskB,
	input fabricDatapathPkg::stateWord_t [`NUM_COMPARATORS-1:0] constant,
	input logic [`NUM_COMPARATORS-1:0] opBMux,
	input fabricDatapathPkg::cmpSel_t [`NUM_COMPARATORS-1:0] resultMux,
	input fabricCheckerPkg::numCks_t [`NUM_CHECKERS-1:0] numCks,
	input fabricCheckerPkg::checkSel_t [`NUM_CHECKERS-1:0] checkSel,
	input logic [`NUM_CHECKERS-1:0] resSel,
	input logic [`NUM_CHECKERS-1:0] assertionsViolated,
	input logic assertionViolated
);

	int failCount = 0;

	fabricDatapathPkg::stateWord_t [`NUM_ROUTERS-1:0] refWord;
	logic [`NUM_ROUTERS-1:0] refRouteBad;
	logic [`NUM_COMPARATORS-1:0] refEvent;
	logic [`NUM_COMPARATORS-1:0] refCmpBad;
	logic [`NUM_CHECKERS-1:0] refComb;
	logic [`NUM_CHECKERS-1:0] refReg;
	logic [`NUM_CHECKERS-1:0] expViol;
	fabricCheckerPkg::ckShift_t [`NUM_CHECKERS-1:0] refHist;
	logic anyBad;

	// unsigned compare codes 0 to 5
	function automatic logic compareRule(input logic [2:0] op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd2: return a < b;
			3'd3: return a <= b;
			3'd4: return a > b;
			3'd5: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model

	always_comb begin
		anyBad = 1'b0;
		for (int r = 0; r < `NUM_ROUTERS; r++) begin
			refRouteBad[r] = routeSel[r] >= 4'(`ROUTE_WORDS);
			refWord[r] = refRouteBad[r] ? '0 : routingInput[routeSel[r]*`WORD_BITS +: `WORD_BITS];
		end
		for (int k = 0; k < `NUM_COMPARATORS; k++) begin
			refEvent[k] = compareRule(resultMux[k], refWord[2*k] & maskA[k],
				opBMux[k] ? constant[k] : (refWord[2*k+1] & maskB[k]));
			refCmpBad[k] = (resultMux[k] > 3'd5) | refRouteBad[2*k] | refRouteBad[2*k+1];
		end
		for (int j = 0; j < `NUM_CHECKERS; j++) begin
			case (checkSel[j])
				2'd0: refComb[j] = refEvent[2*j] & ~refEvent[2*j+1];
				2'd1: refComb[j] = (numCks[j] != 3'd0) && refHist[j][numCks[j] - 3'd1]
					&& !refEvent[2*j+1];
				2'd2: refComb[j] = refEvent[2*j] & refEvent[2*j+1];
				default: refComb[j] = 1'b0;
			endcase
			refComb[j] = refComb[j] & enable;
			expViol[`NUM_CHECKERS-1-j] = resSel[j] ? (refReg[j] & enable) : refComb[j];
			anyBad = anyBad | refCmpBad[2*j] | refCmpBad[2*j+1] | (checkSel[j] == 2'd3)
				| ((checkSel[j] == 2'd1) && (numCks[j] == 3'd0));
		end
	end

	// start history, bit i is a start i+1 cycles back
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			refHist <= '0;
			refReg <= '0;
		end else if (!enable) begin
			refHist <= '0;
			refReg <= '0;
		end else begin
			for (int j = 0; j < `NUM_CHECKERS; j++) begin
				refHist[j] <= {refHist[j][`MAX_CKS-2:0], refEvent[2*j]};
				refReg[j] <= refComb[j];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks

	assert property (@(posedge clk) disable iff (!arstN) assertionsViolated == expViol)
		else begin failCount++; $error("mismatch in violation vector"); end

	assert property (@(posedge clk) disable iff (!arstN)
		assertionViolated == ((|expViol) && !anyBad))
		else begin failCount++; $error("mismatch in merged violation flag"); end

	assert property (@(posedge clk) disable iff (!arstN) anyBad |-> !assertionViolated)
		else begin failCount++; $error("merged flag raised with invalid configuration"); end

	assert property (@(posedge clk) disable iff (!arstN)
		!enable |-> (assertionsViolated == '0) && !assertionViolated)
		else begin failCount++; $error("violation seen while disabled"); end

	for (genvar j = 0; j < `NUM_CHECKERS; j++) begin : genRegCheck
		// registered path lags the combinational rule by one clock
		assert property (@(posedge clk) disable iff (!arstN)
			resSel[j] && enable && $past(enable) |->
			assertionsViolated[`NUM_CHECKERS-1-j] == $past(refComb[j]))
			else begin failCount++; $error("mismatch in registered result"); end
	end

endmodule

bind assertionFabric fabric_assertions u_fabricAssertions (.*);

//--- sim/tb_assertionFabric.sv
`timescale 1ns/1ps
`include "fabric_consts.svh"

module tb_assertionFabric;

	localparam int idleCycles = 16;
	localparam int randomCycles = 100;
	localparam int nextCycles = 12;
	localparam int disableCycles = 4;
	localparam int holdConfigs = 15;
	localparam int holdCycles = 4;
	localparam int invalidCycles = 12;
	localparam int testCycles = 3 + idleCycles + randomCycles + `MAX_CKS * nextCycles
		+ disableCycles + holdConfigs * holdCycles + 4 * invalidCycles + 6;
	localparam int timeoutCycles = 2 * testCycles;

	logic clk = 1'b0;
	logic arstN;
	logic enable;
	fabricDatapathPkg::routeBus_t routingInput;
	fabricDatapathPkg::routeSel_t [`NUM_ROUTERS-1:0] routeSel;
	fabricDatapathPkg::stateWord_t [`NUM_COMPARATORS-1:0] maskA;
	fabricDatapathPkg::stateWord_t [`NUM_COMPARATORS-1:0] maskB;
	fabricDatapathPkg::stateWord_t [`NUM_COMPARATORS-1:0] constant;
	logic [`NUM_COMPARATORS-1:0] opBMux;
	fabricDatapathPkg::cmpSel_t [`NUM_COMPARATORS-1:0] resultMux;
	fabricCheckerPkg::numCks_t [`NUM_CHECKERS-1:0] numCks;
	fabricCheckerPkg::checkSel_t [`NUM_CHECKERS-1:0] checkSel;
	logic [`NUM_CHECKERS-1:0] resSel;
	logic [`NUM_CHECKERS-1:0] assertionsViolated;
	logic assertionViolated;

	int cycleCount = 0;
	int failMark = 0;
	int testsRun = 0;
	int testsFailed = 0;

	assertionFabric u_assertionFabric (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			$display("run timed out after %0d cycles", cycleCount);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers

	// narrow masks and small constants so equal compares happen often
	task automatic randomizeDatapath();
		for (int w = 0; w < `ROUTE_WORDS; w++) begin
			routingInput[w*`WORD_BITS +: `WORD_BITS] = $urandom();
		end
		for (int r = 0; r < `NUM_ROUTERS; r++) begin
			routeSel[r] = 4'($urandom_range(0, `ROUTE_WORDS - 1));
		end
		for (int k = 0; k < `NUM_COMPARATORS; k++) begin
			maskA[k] = $urandom() >> $urandom_range(24, 31);
			maskB[k] = $urandom() >> $urandom_range(24, 31);
			constant[k] = $urandom_range(0, 7);
			opBMux[k] = 1'($urandom_range(0, 1));
			resultMux[k] = 3'($urandom_range(0, 5));
		end
	endtask

	// masked-off operand against constant 0, so equal gives 1 and not-equal 0
	task automatic setEventLevel(input int k, input logic level);
		maskA[k] = '0;
		opBMux[k] = 1'b1;
		constant[k] = '0;
		resultMux[k] = level ? 3'd0 : 3'd1;
	endtask

	task automatic reportTest(input string name);
		int raised;
		@(negedge clk);
		raised = u_assertionFabric.u_fabricAssertions.failCount - failMark;
		testsRun++;
		if (raised == 0) begin
			$display("test %s passed", name);
		end else begin
			testsFailed++;
			$display("mismatch at time %0t: test %s raised %0d assertion failures",
				$time, name, raised);
		end
		failMark = u_assertionFabric.u_fabricAssertions.failCount;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests

	initial begin
		void'($urandom(32'h521e8a7c));
		arstN = 1'b0;
		enable = 1'b0;
		routingInput = '0;
		routeSel = '0;
		maskA = '0;
		maskB = '0;
		constant = '0;
		opBMux = '0;
		resultMux = '0;
		numCks = '0;
		checkSel = '0;
		resSel = '0;
		repeat (3) @(negedge clk);
		arstN = 1'b1;

		repeat (idleCycles) begin
			@(negedge clk);
			randomizeDatapath();
			resSel = 2'($urandom_range(0, 3));
		end
		reportTest("reset and disabled idle");

		enable = 1'b1;
		resSel = '0;
		repeat (randomCycles) begin
			@(negedge clk);
			randomizeDatapath();
			for (int j = 0; j < `NUM_CHECKERS; j++) begin
				checkSel[j] = ($urandom_range(0, 1) == 0) ? 2'd0 : 2'd2;
			end
		end
		reportTest("implication and never modes");

		// starts at 50 percent give runs of events in flight
		for (int n = 1; n <= `MAX_CKS; n++) begin
			checkSel = {2'd1, 2'd1};
			numCks = {3'(n), 3'(n)};
			repeat (nextCycles) begin
				@(negedge clk);
				for (int j = 0; j < `NUM_CHECKERS; j++) begin
					setEventLevel(2*j, 1'($urandom_range(0, 1)));
					setEventLevel(2*j+1, $urandom_range(0, 3) != 0);
				end
			end
		end
		reportTest("next mode over all cycle counts");

		// drop enable with a start in history and a registered result set
		checkSel = '0;
		resSel = '1;
		for (int j = 0; j < `NUM_CHECKERS; j++) begin
			setEventLevel(2*j, 1'b1);
			setEventLevel(2*j+1, 1'b0);
		end
		@(negedge clk);
		enable = 1'b0;
		repeat (2) @(negedge clk);
		// any start left in history would now show as a violation
		enable = 1'b1;
		checkSel = {2'd1, 2'd1};
		numCks = {3'd1, 3'd1};
		for (int j = 0; j < `NUM_CHECKERS; j++) begin
			setEventLevel(2*j, 1'b0);
		end
		repeat (2) @(negedge clk);
		reportTest("enable dropped mid-run");

		resSel = '1;
		repeat (holdConfigs) begin
			@(negedge clk);
			randomizeDatapath();
			for (int j = 0; j < `NUM_CHECKERS; j++) begin
				checkSel[j] = 2'($urandom_range(0, 2));
				numCks[j] = 3'($urandom_range(1, `MAX_CKS));
			end
			repeat (holdCycles - 1) @(negedge clk);
		end
		reportTest("registered result");

		for (int c = 0; c < 4; c++) begin
			repeat (invalidCycles) begin
				@(negedge clk);
				randomizeDatapath();
				resSel = 2'($urandom_range(0, 3));
				for (int j = 0; j < `NUM_CHECKERS; j++) begin
					checkSel[j] = 2'($urandom_range(0, 2));
					numCks[j] = 3'($urandom_range(1, `MAX_CKS));
				end
				case (c)
					0: routeSel[$urandom_range(0, 7)] = 4'($urandom_range(12, 15));
					1: resultMux[$urandom_range(0, 3)] = 3'($urandom_range(6, 7));
					2: checkSel[$urandom_range(0, 1)] = 2'd3;
					default: begin
						checkSel[1] = 2'd1;
						numCks[1] = 3'd0;
					end
				endcase
			end
		end
		reportTest("invalid configuration gating");

		$display("tests run %0d, passed %0d, failed %0d", testsRun,
			testsRun - testsFailed, testsFailed);
		if (testsFailed == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+hdl
hdl/fabricDatapathPkg.sv
hdl/fabricCheckerPkg.sv
hdl/compareCfgIf.sv
hdl/signalRouter.sv
hdl/stateComparator.sv
hdl/temporalChecker.sv
hdl/checkerBank.sv
hdl/assertionFabric.sv
sim/fabric_assertions.sv
sim/tb_assertionFabric.sv

//--- run.sh
#!/usr/bin/env bash
# compile with Verilator, run, and judge the result from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f \
	--top-module tb_assertionFabric -o simv \
	&& ./obj_dir/simv +verilator+error+limit+1000 2>&1 | tee sim.log \
	|| echo "build or run step failed"

grep -qx "SIMULATION PASSED" sim.log \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }
